// ==== dv/macBusGlueTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module macBusGlueTb;
	import gluePkg::*;

	localparam int ramAddrBits = 10;
	localparam int romAddrBits = 8;
	localparam int ramWait = 1;
	localparam int romWait = 3;
	localparam int ioTimeout = 20;
	localparam int clkPeriod = 4;
	localparam int resetCycles = 16;
	localparam int ramOps = 40;
	localparam int romOps = 4;
	localparam int randOps = 60;
	localparam int cycleLimit = ioTimeout + 10; // clocks until a stuck cycle is flagged
	localparam int plannedCycles = 5 + ramOps + 2 * romOps + randOps + 12 + 2;
	localparam int watchdogTime = (resetCycles + plannedCycles * 2000) * clkPeriod;

	// directed decode points as {byte address, rwN}
	localparam logic [24:0] directedOps [12] = '{
		{24'h436C00, 1'b1}, {24'h436D40, 1'b1}, {24'h436E00, 1'b1}, {24'h436F80, 1'b1},
		{24'h3FFD00, 1'b0}, {24'h3FFF10, 1'b0}, {24'h3FA200, 1'b0}, {24'h3FA400, 1'b0},
		{24'h3F2000, 1'b0}, {24'h3F1000, 1'b0}, {24'hFFFFF0, 1'b1}, {24'h3FFD00, 1'b1}
	};

	logic CLK;
	logic rstN;
	logic asN;
	logic udsN;
	logic ldsN;
	logic rwN;
	logic ioAck;
	logic [23:1] addr;
	logic [15:0] dataIn;
	logic [15:0] dataOut;
	logic dtackN;
	logic berrN;
	logic ioCs;
	logic ioPwCs;
	logic iaCs;
	logic sndRomCs;
	logic sndRamCsWr;

	logic [31:0] lcgState = 32'hf258_d4f6;
	int errCount = 0;     // immediate checks
	int propErrCount = 0; // concurrent checks
	int checkCount = 0;
	int cycleCount = 0;
	bit refOverlay = 1'b1;                    // boot overlay as the DUT should hold it
	logic [15:0] ramModel [2**ramAddrBits];
	logic [1:0] ramKnown [2**ramAddrBits];    // byte lanes written so far

	macBusGlue #(
		.ramAddrBits (ramAddrBits),
		.romAddrBits (romAddrBits),
		.ramWait     (ramWait),
		.romWait     (romWait),
		.ioTimeout   (ioTimeout),
		.timerBits   (5)
	) macBusGlue_inst (
		.CLK        (CLK),
		.rstN       (rstN),
		.asN        (asN),
		.udsN       (udsN),
		.ldsN       (ldsN),
		.rwN        (rwN),
		.addr       (addr),
		.dataIn     (dataIn),
		.dataOut    (dataOut),
		.dtackN     (dtackN),
		.berrN      (berrN),
		.ioCs       (ioCs),
		.ioPwCs     (ioPwCs),
		.iaCs       (iaCs),
		.sndRomCs   (sndRomCs),
		.sndRamCsWr (sndRamCsWr),
		.ioAck      (ioAck)
	);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	// both acknowledges never low at once
	assert property (@(posedge CLK) disable iff (!rstN) dtackN || berrN)
	else begin
		propErrCount++;
		$display("%0t: DTACK and BERR were low together", $time);
	end

	// AS high releases both acknowledges by the next edge
	assert property (@(posedge CLK) disable iff (!rstN) asN |=> (dtackN && berrN))
	else begin
		propErrCount++;
		$display("%0t: an acknowledge stayed low after AS went high", $time);
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223; // full period mod 2^32
		return lcgState;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		checkCount++;
		assert (actVal === expVal)
		else begin
			errCount++;
			$display("error at %0t ns: %s expected %0h actual %0h", $time, name, expVal, actVal);
		end
	endtask

	// reference decoder on the byte address
	task automatic refDecode(input logic [23:0] a, input logic rw, input bit ovl,
			output bit romC, output bit ramC, output bit io, output bit pw,
			output bit ia, output bit sndRom, output bit sndRam, output bit rom4x);
		bit vid64k;
		rom4x = a[23:20] == 4'h4;
		romC = rom4x || (ovl && a[23:20] == 4'h0);
		sndRom = rom4x && a[20:10] == 11'h0DB && a[9:8] != 2'b10; // pages 36C, 36D, 36F
		ramC = !ovl && a[23:22] == 2'b00;
		vid64k = !rw && a[23:16] == 8'h3F;
		pw = vid64k && ((a[15:12] >= 4'h2 && a[15:12] <= 4'h7) || a[15:12] >= 4'hA);
		sndRam = vid64k && ((a[15:12] == 4'hF && a[11:8] >= 4'hD) ||
			(a[15:12] == 4'hA && a[11:8] != 4'h0 && a[11:8] <= 4'h3));
		ia = a[23:16] == 8'hFF;
		io = a[23:20] >= 4'h5 || (ovl && rom4x) || pw;
	endtask

	// one 68000 cycle where ackDelay 0 leaves ioAck low for BERR
	task automatic busCycle(input logic [23:0] a, input logic rw, input logic [1:0] lanes,
			input int ackDelay);
		logic [15:0] wd;
		logic [15:0] mask;
		logic [ramAddrBits-1:0] idx;
		logic [1:0] ackLevel;
		logic [31:0] tmp;
		bit romC, ramC, io, pw, ia, sndRom, sndRam, rom4x;
		bit expBerr;
		int lat;
		int expEdges;
		wd = 16'(nextRand() >> 16);
		idx = a[ramAddrBits:1]; // mirror index
		refDecode(a, rw, refOverlay, romC, ramC, io, pw, ia, sndRom, sndRam, rom4x);
		@(negedge CLK);
		addr = a[23:1];
		rwN = rw;
		dataIn = wd;
		udsN = !lanes[1];
		ldsN = !lanes[0];
		asN = 1'b0;
		lat = 0;
		while (dtackN && berrN && lat < cycleLimit) begin
			@(negedge CLK);
			lat++;
			if (lat == 1) begin // after the edge that samples AS
				checkValue("ioCs", 32'(io), 32'(ioCs));
				checkValue("ioPwCs", 32'(pw), 32'(ioPwCs));
				checkValue("iaCs", 32'(ia), 32'(iaCs));
				checkValue("sndRomCs", 32'(sndRom), 32'(sndRomCs));
				checkValue("sndRamCsWr", 32'(sndRam), 32'(sndRamCsWr));
			end
			if (io && lat == ackDelay) begin
				ioAck = 1'b1; // sampled on the next edge
			end
		end
		if (dtackN && berrN) begin
			errCount++;
			$display("%0t: cycle at %06h got neither DTACK nor BERR", $time, a);
		end else begin
			expBerr = io && ackDelay == 0;
			expEdges = io ? (expBerr ? ioTimeout + 2 : ackDelay + 1) :
				(romC ? romWait + 2 : ramWait + 2);
			checkValue("acknowledge edge", 32'(expEdges), 32'(lat - 1));
			checkValue("berrN", 32'(!expBerr), 32'(berrN));
			checkValue("dtackN", 32'(expBerr), 32'(dtackN));
			if (!io && rw && romC) begin
				checkValue("dataOut", 32'(romFillBase + 16'(a[romAddrBits:1])), 32'(dataOut));
			end else if (!io && rw && ramC) begin
				mask = {{8{ramKnown[idx][1]}}, {8{ramKnown[idx][0]}}}; // unknown bytes skipped
				checkValue("dataOut", 32'(ramModel[idx] & mask), 32'(dataOut & mask));
			end else if (!io && !rw && ramC && !romC) begin
				if (lanes[1]) begin
					ramModel[idx][15:8] = wd[15:8];
				end
				if (lanes[0]) begin
					ramModel[idx][7:0] = wd[7:0];
				end
				ramKnown[idx] = ramKnown[idx] | lanes;
			end
		end
		// master stretches the cycle while the acknowledge holds
		ackLevel = {dtackN, berrN};
		tmp = nextRand();
		repeat (int'(tmp[29:28]) % 3) begin
			@(negedge CLK);
			checkValue("dtackN,berrN held", 32'(ackLevel), 32'({dtackN, berrN}));
		end
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		rwN = 1'b1;
		ioAck = 1'b0;
		@(negedge CLK);
		checkValue("dtackN,berrN released", 32'(2'b11), 32'({dtackN, berrN}));
		if (rom4x) begin
			refOverlay = 1'b0; // any 4x hit drops the overlay
		end
		cycleCount++;
	endtask

	initial begin
		logic [23:0] a;
		logic [31:0] tmp;
		logic [1:0] lanes;
		int delay;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		rwN = 1'b1;
		ioAck = 1'b0;
		addr = '0;
		dataIn = '0;
		rstN = 1'b0;
		for (int i = 0; i < 2**ramAddrBits; i++) begin
			ramKnown[i] = 2'b00;
			ramModel[i] = 16'h0000;
		end
		repeat (resetCycles) @(negedge CLK);
		rstN = 1'b1;
		@(negedge CLK);
		checkValue("dtackN,berrN after reset", 32'(2'b11), 32'({dtackN, berrN}));

		// boot overlay then its release
		busCycle(24'h000000, 1'b1, 2'b11, 0);            // ROM word 0 at zero
		busCycle(24'h400010, 1'b1, 2'b11, 7);            // first 4x hit goes to the I/O side
		busCycle(24'h400010, 1'b1, 2'b11, 0);            // now plain ROM
		busCycle(24'h000000, 1'b0, 2'b11, 0);
		busCycle(24'h000000, 1'b1, 2'b11, 0);            // RAM at zero

		// RAM lanes and mirrors over 16 words under random upper bits
		for (int i = 0; i < ramOps; i++) begin
			tmp = nextRand();
			a = tmp[31:8];
			a[23:22] = 2'b00;
			a[10:5] = '0;
			a[0] = 1'b0;
			if (a[21:16] == 6'h3F) begin
				a[16] = 1'b0; // keep clear of the video window
			end
			lanes = tmp[17:16];
			if (lanes == 2'b00) begin
				lanes = 2'b11;
			end
			busCycle(a, tmp[30], lanes, 0);
		end

		// ROM writes are dropped
		for (int i = 0; i < romOps; i++) begin
			tmp = nextRand();
			a = {4'h4, tmp[27:8]};
			a[0] = 1'b0;
			busCycle(a, 1'b0, 2'b11, 0);
			busCycle(a, 1'b1, 2'b11, 0);
		end

		// whole map with random I/O ack or timeout
		for (int i = 0; i < randOps; i++) begin
			tmp = nextRand();
			a = tmp[31:8];
			a[0] = 1'b0;
			delay = tmp[7:5] < 3'd2 ? 0 : 1 + int'(tmp[15:8]) % (ioTimeout - 2);
			busCycle(a, tmp[4], 2'b11, delay);
		end

		for (int i = 0; i < 12; i++) begin
			tmp = nextRand();
			busCycle(directedOps[i][24:1], directedOps[i][0], 2'b11,
				1 + int'(tmp[23:16]) % (ioTimeout - 2));
		end

		busCycle(24'hE00000, 1'b1, 2'b11, 0); // no ack gives a bus error
		busCycle(24'h9FFFFE, 1'b0, 2'b11, 0);

		$display("bus cycles %0d, checks %0d, errors %0d, property errors %0d",
			cycleCount, checkCount, errCount, propErrCount);
		if (errCount == 0 && propErrCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdogTime);
		$display("watchdog: run did not finish within %0d ns", watchdogTime);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
source/gluePkg.sv
source/selIf.sv
source/memIf.sv
source/addrDecode.sv
source/waitTimer.sv
source/ramArray.sv
source/romArray.sv
source/busCycleFsm.sv
source/macBusGlue.sv
dv/macBusGlueTb.sv

// ==== rom.hex ====
// boot ROM, 16 words per line, word i = a500 + i
a500 a501 a502 a503 a504 a505 a506 a507 a508 a509 a50a a50b a50c a50d a50e a50f
a510 a511 a512 a513 a514 a515 a516 a517 a518 a519 a51a a51b a51c a51d a51e a51f
a520 a521 a522 a523 a524 a525 a526 a527 a528 a529 a52a a52b a52c a52d a52e a52f
a530 a531 a532 a533 a534 a535 a536 a537 a538 a539 a53a a53b a53c a53d a53e a53f
a540 a541 a542 a543 a544 a545 a546 a547 a548 a549 a54a a54b a54c a54d a54e a54f
a550 a551 a552 a553 a554 a555 a556 a557 a558 a559 a55a a55b a55c a55d a55e a55f
a560 a561 a562 a563 a564 a565 a566 a567 a568 a569 a56a a56b a56c a56d a56e a56f
a570 a571 a572 a573 a574 a575 a576 a577 a578 a579 a57a a57b a57c a57d a57e a57f
a580 a581 a582 a583 a584 a585 a586 a587 a588 a589 a58a a58b a58c a58d a58e a58f
a590 a591 a592 a593 a594 a595 a596 a597 a598 a599 a59a a59b a59c a59d a59e a59f
a5a0 a5a1 a5a2 a5a3 a5a4 a5a5 a5a6 a5a7 a5a8 a5a9 a5aa a5ab a5ac a5ad a5ae a5af
a5b0 a5b1 a5b2 a5b3 a5b4 a5b5 a5b6 a5b7 a5b8 a5b9 a5ba a5bb a5bc a5bd a5be a5bf
a5c0 a5c1 a5c2 a5c3 a5c4 a5c5 a5c6 a5c7 a5c8 a5c9 a5ca a5cb a5cc a5cd a5ce a5cf
a5d0 a5d1 a5d2 a5d3 a5d4 a5d5 a5d6 a5d7 a5d8 a5d9 a5da a5db a5dc a5dd a5de a5df
a5e0 a5e1 a5e2 a5e3 a5e4 a5e5 a5e6 a5e7 a5e8 a5e9 a5ea a5eb a5ec a5ed a5ee a5ef
a5f0 a5f1 a5f2 a5f3 a5f4 a5f5 a5f6 a5f7 a5f8 a5f9 a5fa a5fb a5fc a5fd a5fe a5ff

// ==== run.sh ====
#!/bin/sh
# build and run the bus glue testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module macBusGlueTb -f files.f -o simMacBusGlue
./obj_dir/simMacBusGlue > sim.log
cat sim.log
if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
echo "simulation passed"

// ==== source/addrDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module addrDecode (
	input logic CLK,
	input logic rstN,
	input logic [gluePkg::addrBits-1:0] addr,
	input logic rwN,
	selIf.decoder sel
);

	logic overlay;   // ROM mirrored at 0 after reset
	logic vidWin64k; // write into 0x3Fxxxx
	logic vidWin;    // video RAM write pages

	// boot overlay dropped once code runs from the 4x window
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			overlay <= 1'b1;
		end else if (sel.bact && sel.romCs4x) begin
			overlay <= 1'b0; // sticks until next reset
		end
	end

	// ROM side
	assign sel.romCs4x = addr[23:20] == 4'h4;
	assign sel.romCs = (addr[23:20] == 4'h0 && overlay) || sel.romCs4x;
	assign sel.sndRomCs = sel.romCs4x &&
		(addr[20:8] == 13'h036C || addr[20:8] == 13'h036D ||
		addr[20:8] == 13'h036F); // sound ROM pages

	// RAM side
	assign sel.ramCs0x = addr[23:22] == 2'b00;
	assign sel.ramCs = sel.ramCs0x && !overlay;

	assign vidWin64k = sel.ramCs0x && !rwN && addr[23:16] == 8'h3F;
	assign vidWin = vidWin64k &&
		(addr[15:12] inside {[4'h2:4'h7], [4'hA:4'hF]}); // frame buffer pages

	// sound buffer shares the top of the video pages
	assign sel.sndRamCsWr = vidWin64k && (
		(addr[15:12] == 4'hF && addr[11:8] inside {[4'hD:4'hF]}) ||
		(addr[15:12] == 4'hA && addr[11:8] inside {[4'h1:4'h3]}));

	// I/O side decoded from the address alone without AS
	assign sel.iaCs = addr[23:16] == 8'hFF; // IACK cycles
	assign sel.ioCs = addr[23:20] inside {[4'h5:4'hF]} || // SCSI, SCC, IWM, VIA, IACK
		(addr[23:20] == 4'h4 && overlay) || // first 4x hit
		vidWin; // video writes go through I/O side too
	assign sel.ioPwCs = vidWin;

endmodule

`default_nettype wire

// ==== source/busCycleFsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module busCycleFsm #(
	parameter int ramWait = 1,
	parameter int romWait = 3,
	parameter int ioTimeout = 20,
	parameter int timerBits = 5
) (
	input logic CLK,
	input logic rstN,
	input logic asN,
	input logic udsN,
	input logic ldsN,
	input logic rwN,
	input logic [gluePkg::addrBits-1:1] addr,
	input logic [gluePkg::dataBits-1:0] dataIn,
	input logic ioAck,
	output logic dtackN,
	output logic berrN,
	output logic [gluePkg::dataBits-1:0] dataOut,
	selIf.ctrl sel,
	memIf.master ramMem,
	memIf.master romMem,
	output logic [timerBits-1:0] tmrLoad,
	output logic tmrStart,
	input logic tmrDone
);
	import gluePkg::*;

	busState state;
	busState stateNext;
	logic ioAckQ;                   // external ack through one flop
	logic selRamQ;                  // cycle latched to RAM
	logic selRomQ;                  // cycle latched to ROM
	logic rwNQ;
	logic [1:0] byteEnQ;
	logic [addrBits-2:0] wordAddrQ;
	logic [dataBits-1:0] dataQ;
	logic wrStb;

	always_comb begin
		stateNext = state;
		case (state)
			idle: if (!asN) stateNext = decode; // edge 0
			decode: begin
				if (asN) stateNext = idle; // strobe dropped early
				else if (sel.ioCs) stateNext = waitIo; // I/O wins over memory
				else if (sel.romCs || sel.ramCs) stateNext = waitMem;
				else stateNext = busErr; // unmapped such as RAM under overlay
			end
			waitMem: begin
				if (asN) stateNext = idle;
				else if (tmrDone) stateNext = ack;
			end
			waitIo: begin
				if (asN) stateNext = idle;
				else if (ioAckQ) stateNext = ack; // ack beats timeout on same edge
				else if (tmrDone) stateNext = busErr;
			end
			ack, busErr: if (asN) stateNext = idle; // hold until AS rises
			default: stateNext = idle;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			dtackN <= 1'b1;
			berrN <= 1'b1;
			ioAckQ <= 1'b0;
			selRamQ <= 1'b0;
			selRomQ <= 1'b0;
		end else begin
			state <= stateNext;
			dtackN <= stateNext != ack; // low for the whole ack state
			berrN <= stateNext != busErr;
			ioAckQ <= ioAck;
			if (state == decode) begin
				selRomQ <= !sel.ioCs && sel.romCs;
				selRamQ <= !sel.ioCs && !sel.romCs && sel.ramCs;
			end else if (stateNext == idle) begin
				selRomQ <= 1'b0;
				selRamQ <= 1'b0;
			end
		end
	end

	// cycle payload latched once per cycle
	always_ff @(posedge CLK) begin
		if (state == decode) begin
			wordAddrQ <= addr;
			dataQ <= dataIn;
			byteEnQ <= {!udsN, !ldsN}; // strobes are active low
			rwNQ <= rwN;
		end
	end

	// timer takes the memory wait or I/O timeout on the path edge
	assign tmrStart = state == decode;
	always_comb begin
		if (sel.ioCs || !(sel.romCs || sel.ramCs)) tmrLoad = timerBits'(ioTimeout);
		else if (sel.romCs) tmrLoad = timerBits'(romWait);
		else tmrLoad = timerBits'(ramWait);
	end

	assign sel.bact = state != idle; // low again the edge AS is seen high

	// write lands on the edge DTACK falls
	assign wrStb = state == waitMem && tmrDone && !asN && !rwNQ;

	assign ramMem.wordAddr = wordAddrQ;
	assign ramMem.wrData = dataQ;
	assign ramMem.byteEn = byteEnQ;
	assign ramMem.wrStb = wrStb;
	assign ramMem.sel = selRamQ;

	assign romMem.wordAddr = wordAddrQ;
	assign romMem.wrData = dataQ;
	assign romMem.byteEn = byteEnQ;
	assign romMem.wrStb = wrStb; // acked and dropped by ROM
	assign romMem.sel = selRomQ;

	// unselected memory reads back zero
	assign dataOut = selRomQ ? romMem.rdData : ramMem.rdData;

endmodule

`default_nettype wire

// ==== source/gluePkg.sv ====
`default_nettype none

package gluePkg;

	// 68000 byte address and data bus
	parameter int addrBits = 24; // A23..A0 with A0 implied by the strobes
	parameter int dataBits = 16; // D15..D0

	// boot ROM image holds romFillBase + i in word i
	parameter logic [dataBits-1:0] romFillBase = 16'hA500;

	// bus-cycle controller states
	typedef enum logic [2:0] {
		idle,    // waiting for address strobe
		decode,  // selects settle before the path edge
		waitMem, // RAM/ROM wait states counting
		waitIo,  // waiting on external ack or timeout
		ack,     // DTACK low until AS rises
		busErr   // BERR low until AS rises
	} busState;

endpackage

`default_nettype wire

// ==== source/macBusGlue.sv ====
`timescale 1ns/10ps
`default_nettype none

module macBusGlue #(
	parameter int ramAddrBits = 10, // 1K words
	parameter int romAddrBits = 8,  // 256 words
	parameter int ramWait = 1,
	parameter int romWait = 3,
	parameter int ioTimeout = 20,
	parameter int timerBits = 5     // must hold ioTimeout
) (
	input logic CLK,
	input logic rstN,
	input logic asN,
	input logic udsN,
	input logic ldsN,
	input logic rwN,
	input logic [gluePkg::addrBits-1:1] addr,
	input logic [gluePkg::dataBits-1:0] dataIn,
	output logic [gluePkg::dataBits-1:0] dataOut,
	output logic dtackN,
	output logic berrN,
	output logic ioCs,
	output logic ioPwCs,
	output logic iaCs,
	output logic sndRomCs,
	output logic sndRamCsWr,
	input logic ioAck
);

	logic [timerBits-1:0] tmrLoad;
	logic tmrStart;
	logic tmrDone;

	selIf selBus ();
	memIf ramBus ();
	memIf romBus ();

	addrDecode addrDecode_inst (
		.CLK  (CLK),
		.rstN (rstN),
		.addr ({addr, 1'b0}), // A0 implied by UDS/LDS
		.rwN  (rwN),
		.sel  (selBus.decoder)
	);

	busCycleFsm #(
		.ramWait   (ramWait),
		.romWait   (romWait),
		.ioTimeout (ioTimeout),
		.timerBits (timerBits)
	) busCycleFsm_inst (
		.CLK      (CLK),
		.rstN     (rstN),
		.asN      (asN),
		.udsN     (udsN),
		.ldsN     (ldsN),
		.rwN      (rwN),
		.addr     (addr),
		.dataIn   (dataIn),
		.ioAck    (ioAck),
		.dtackN   (dtackN),
		.berrN    (berrN),
		.dataOut  (dataOut),
		.sel      (selBus.ctrl),
		.ramMem   (ramBus.master),
		.romMem   (romBus.master),
		.tmrLoad  (tmrLoad),
		.tmrStart (tmrStart),
		.tmrDone  (tmrDone)
	);

	waitTimer #(
		.timerBits (timerBits)
	) waitTimer_inst (
		.CLK   (CLK),
		.rstN  (rstN),
		.load  (tmrLoad),
		.start (tmrStart),
		.done  (tmrDone)
	);

	ramArray #(
		.ramAddrBits (ramAddrBits)
	) ramArray_inst (
		.CLK (CLK),
		.mem (ramBus.target)
	);

	romArray #(
		.romAddrBits (romAddrBits)
	) romArray_inst (
		.CLK (CLK),
		.mem (romBus.target)
	);

	// I/O side selects go straight out to the devices
	assign ioCs = selBus.ioCs;
	assign ioPwCs = selBus.ioPwCs;
	assign iaCs = selBus.iaCs;
	assign sndRomCs = selBus.sndRomCs;
	assign sndRamCsWr = selBus.sndRamCsWr;

endmodule

`default_nettype wire

// ==== source/memIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface memIf;
	import gluePkg::*;

	logic [addrBits-2:0] wordAddr; // A23..A1
	logic [dataBits-1:0] wrData;
	logic [dataBits-1:0] rdData;   // zero while sel is low
	logic [1:0] byteEn;            // {upper, lower} lane
	logic wrStb;                   // one-cycle write pulse
	logic sel;                     // this memory owns the cycle

	modport master (
		output wordAddr, wrData, byteEn, wrStb, sel,
		input rdData
	);

	modport target (
		input wordAddr, wrData, byteEn, wrStb, sel,
		output rdData
	);

endinterface

`default_nettype wire

// ==== source/ramArray.sv ====
`timescale 1ns/10ps
`default_nettype none

module ramArray #(
	parameter int ramAddrBits = 10
) (
	input logic CLK,
	memIf.target mem
);
	import gluePkg::*;

	logic [dataBits-1:0] ramWords [2**ramAddrBits]; // one entry per RAM word
	logic [ramAddrBits-1:0] idx;

	// low word address bits only, so the array repeats over the window
	assign idx = mem.wordAddr[ramAddrBits-1:0];

	always_ff @(posedge CLK) begin
		if (mem.sel && mem.wrStb) begin
			if (mem.byteEn[1]) begin
				ramWords[idx][15:8] <= mem.wrData[15:8]; // UDS lane
			end
			if (mem.byteEn[0]) begin
				ramWords[idx][7:0] <= mem.wrData[7:0]; // LDS lane
			end
		end
	end

	// async read of the latched address
	assign mem.rdData = mem.sel ? ramWords[idx] : '0;

endmodule

`default_nettype wire

// ==== source/romArray.sv ====
`timescale 1ns/10ps
`default_nettype none

module romArray #(
	parameter int romAddrBits = 8
) (
	input logic CLK,
	memIf.target mem
);
	import gluePkg::*;

	logic [dataBits-1:0] romWords [2**romAddrBits];
	logic [dataBits-1:0] romQ; // registered read port

	initial begin
		$readmemh("rom.hex", romWords); // boot image
	end

	// one-cycle read inside the minimum ROM wait
	always_ff @(posedge CLK) begin
		romQ <= romWords[mem.wordAddr[romAddrBits-1:0]]; // mirrors over the window
	end

	// write strobe ignored so ROM writes vanish
	assign mem.rdData = mem.sel ? romQ : '0;

endmodule

`default_nettype wire

// ==== source/selIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface selIf;

	logic romCs;      // ROM at 0 under overlay or in the 4x window
	logic romCs4x;    // 0x4xxxxx ROM window
	logic sndRomCs;   // sound ROM pages inside 4x
	logic ramCs;      // system RAM once overlay is off
	logic ramCs0x;    // low 4MB before the overlay qualifies it
	logic ioCs;       // anything handled on the I/O side
	logic ioPwCs;     // video RAM write window
	logic iaCs;       // interrupt acknowledge space
	logic sndRamCsWr; // sound RAM write pages
	logic bact;       // controller has a cycle in flight

	modport decoder (
		output romCs, romCs4x, sndRomCs, ramCs, ramCs0x,
		output ioCs, ioPwCs, iaCs, sndRamCsWr,
		input bact
	);

	modport ctrl (
		input romCs, romCs4x, sndRomCs, ramCs, ramCs0x,
		input ioCs, ioPwCs, iaCs, sndRamCsWr,
		output bact
	);

endinterface

`default_nettype wire

// ==== source/waitTimer.sv ====
`timescale 1ns/10ps
`default_nettype none

module waitTimer #(
	parameter int timerBits = 5
) (
	input logic CLK,
	input logic rstN,
	input logic [timerBits-1:0] load,
	input logic start,
	output logic done
);

	logic [timerBits-1:0] count;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
		end else if (start) begin
			count <= load; // restart even if still running
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// zero holds until the next start
	assign done = count == '0;

endmodule

`default_nettype wire
